/* include/pcim_dma_defines.svh */
// Width, burst length and queue depth macros for the card-to-host DMA engine
`ifndef PCIM_DMA_DEFINES_SVH
`define PCIM_DMA_DEFINES_SVH

// Bus widths
`define DMA_DATA_W       32
`define DMA_ADDR_W       32
`define DMA_BURST_BEATS  4

// Command fields, in bursts of DMA_BURST_BEATS beats
`define DMA_CARD_IDX_W   16
`define DMA_HOST_IDX_W   20
`define DMA_CNT_W        8
`define DMA_CHAN_W       2

// Status and register port
`define DMA_STAT_W       32
`define DMA_SR_ADDR_W    8

// Queue depths as log2
`define DMA_FIFO_LD      5
`define DMA_DATA_FIFO_LD 6

`endif

/* verilog/pcim_dma_pkg.sv */
// Command and burst record types, issue FSM states
`include "pcim_dma_defines.svh"

package pcim_dma_pkg;

	// 64-bit software command, upper bits ignored
	typedef struct packed {
		logic [63-`DMA_CHAN_W-`DMA_CNT_W-`DMA_CARD_IDX_W-`DMA_HOST_IDX_W:0] pad;
		logic [`DMA_CHAN_W-1:0]     chan;
		logic [`DMA_CNT_W-1:0]      count;     // bursts minus one
		logic [`DMA_CARD_IDX_W-1:0] card_idx;
		logic [`DMA_HOST_IDX_W-1:0] host_idx;
	} dma_cmd_t;

	// One record per issued card read
	typedef struct packed {
		logic [`DMA_HOST_IDX_W-1:0] host_idx;
		logic [`DMA_CHAN_W-1:0]     chan;
	} dma_burst_t;

	typedef enum logic [1:0] {
		ISSUE_IDLE,
		ISSUE_READ,
		ISSUE_QUEUE
	} issue_state_t;

endpackage

/* verilog/dma_fifo.sv */
// Synchronous show-ahead FIFO with occupancy count
`timescale 1ns/1ns

module dma_fifo #(
	parameter int WIDTH     = 8,
	parameter int LOG_DEPTH = 5
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	output logic             full,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty
);
	localparam int DEPTH = 1 << LOG_DEPTH;

	logic [WIDTH-1:0]   mem [DEPTH];
	logic [LOG_DEPTH-1:0] wr_ptr;
	logic [LOG_DEPTH-1:0] rd_ptr;
	logic [LOG_DEPTH:0]   count;
	logic do_wr;
	logic do_rd;

	assign full  = count == (LOG_DEPTH + 1)'(DEPTH);
	assign empty = count == '0;
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Head word is visible without a read
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (LOG_DEPTH + 1)'(do_wr) - (LOG_DEPTH + 1)'(do_rd);
		end
	end

endmodule

/* verilog/burst_issuer.sv */
// burst_if record interface; command queue and FSM issuing card reads
`timescale 1ns/1ns
`include "pcim_dma_defines.svh"

interface burst_if;
	logic                       valid;
	logic                       full;
	logic [`DMA_HOST_IDX_W-1:0] host_idx;
	logic [`DMA_CHAN_W-1:0]     chan;

	modport issuer (output valid, host_idx, chan, input full);
	modport scheduler (input valid, host_idx, chan, output full);
endinterface

module burst_issuer (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      sr_valid,
	input  logic                                      sr_write,
	input  logic [$bits(pcim_dma_pkg::dma_cmd_t)-1:0] sr_data,
	output logic [`DMA_ADDR_W-1:0]                    mem_araddr,
	output logic                                      mem_arvalid,
	input  logic                                      mem_arready,
	burst_if.issuer                                   burst
);
	import pcim_dma_pkg::*;

	localparam int BURST_SHIFT = $clog2(`DMA_BURST_BEATS * `DMA_DATA_W / 8);

	issue_state_t state;
	dma_cmd_t     cmd;
	logic         cq_full;
	logic         cq_empty;
	logic         cq_rd;
	logic [$bits(dma_cmd_t)-1:0] cq_data;

	// Software commands wait here
	dma_fifo #(
		.WIDTH($bits(dma_cmd_t)),
		.LOG_DEPTH(`DMA_FIFO_LD)
	) cmd_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(sr_valid && sr_write),
		.wr_data(sr_data),
		.full(cq_full),
		.rd_en(cq_rd),
		.rd_data(cq_data),
		.empty(cq_empty)
	);

	assign cq_rd       = (state == ISSUE_IDLE) && !cq_empty;
	assign mem_arvalid = state == ISSUE_READ;
	assign mem_araddr  = `DMA_ADDR_W'(cmd.card_idx) << BURST_SHIFT;

	assign burst.valid    = state == ISSUE_QUEUE;
	assign burst.host_idx = cmd.host_idx;
	assign burst.chan     = cmd.chan;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ISSUE_IDLE;
		end else begin
			case (state)
				ISSUE_IDLE: begin
					if (!cq_empty) begin
						cmd   <= cq_data;
						state <= ISSUE_READ;
					end
				end
				ISSUE_READ: begin
					if (mem_arready)
						state <= ISSUE_QUEUE;
				end
				ISSUE_QUEUE: begin
					// Record accepted, step to the next burst
					if (!burst.full) begin
						cmd.card_idx <= cmd.card_idx + 1'b1;
						cmd.host_idx <= cmd.host_idx + 1'b1;
						cmd.count    <= cmd.count - 1'b1;
						state <= (cmd.count == '0) ? ISSUE_IDLE : ISSUE_READ;
					end
				end
				default: state <= ISSUE_IDLE;
			endcase
		end
	end

	a_cmd_no_overflow: assert property (@(posedge clk) disable iff (rst)
		!(sr_valid && sr_write && cq_full));

endmodule

/* verilog/write_scheduler.sv */
// Data buffer, write-address credits and host write issue
`timescale 1ns/1ns
`include "pcim_dma_defines.svh"

module write_scheduler (
	input  logic                   clk,
	input  logic                   rst,
	burst_if.scheduler             burst,
	input  logic [`DMA_DATA_W-1:0] mem_rdata,
	input  logic                   mem_rlast,
	input  logic                   mem_rvalid,
	output logic                   mem_rready,
	output logic [`DMA_ADDR_W-1:0] host_awaddr,
	output logic                   host_awvalid,
	input  logic                   host_awready,
	output logic [`DMA_DATA_W-1:0] host_wdata,
	output logic                   host_wlast,
	output logic                   host_wvalid,
	input  logic                   host_wready,
	input  logic                   chan_full,
	output logic                   aw_issued,
	output logic [`DMA_CHAN_W-1:0] aw_chan
);
	import pcim_dma_pkg::*;

	localparam int BURST_SHIFT = $clog2(`DMA_BURST_BEATS * `DMA_DATA_W / 8);
	localparam int CRED_W      = `DMA_FIFO_LD + 2;

	dma_burst_t bq_in;
	dma_burst_t bq_out;
	logic       bq_empty;
	logic       db_full;
	logic       db_empty;
	logic       db_wr;
	logic       aw_fire;
	logic       first_beat;
	logic       add_cred;
	logic [CRED_W-1:0] creds;

	assign bq_in = '{host_idx: burst.host_idx, chan: burst.chan};

	dma_fifo #(
		.WIDTH($bits(dma_burst_t)),
		.LOG_DEPTH(`DMA_FIFO_LD)
	) burst_fifo (
		.clk(clk), .rst(rst),
		.wr_en(burst.valid && !burst.full), .wr_data(bq_in), .full(burst.full),
		.rd_en(aw_fire), .rd_data(bq_out), .empty(bq_empty)
	);

	// Card beats stream straight through to the host
	assign mem_rready  = !db_full;
	assign db_wr       = mem_rvalid && mem_rready;
	assign host_wvalid = !db_empty;

	dma_fifo #(
		.WIDTH(`DMA_DATA_W + 1),
		.LOG_DEPTH(`DMA_DATA_FIFO_LD)
	) data_fifo (
		.clk(clk), .rst(rst),
		.wr_en(db_wr), .wr_data({mem_rdata, mem_rlast}), .full(db_full),
		.rd_en(host_wvalid && host_wready), .rd_data({host_wdata, host_wlast}),
		.empty(db_empty)
	);

	// A burst's address goes out only once its data has started
	assign add_cred     = db_wr && first_beat;
	assign host_awvalid = !bq_empty && (creds != '0) && !chan_full;
	assign host_awaddr  = `DMA_ADDR_W'(bq_out.host_idx) << BURST_SHIFT;
	assign aw_fire      = host_awvalid && host_awready;
	assign aw_issued    = aw_fire;
	assign aw_chan      = bq_out.chan;

	always_ff @(posedge clk) begin
		if (rst) begin
			first_beat <= 1'b1;
			creds      <= '0;
		end else begin
			if (db_wr)
				first_beat <= mem_rlast;
			creds <= creds + CRED_W'(add_cred) - CRED_W'(aw_fire);
		end
	end

	// Address and data held until the host takes them
	a_aw_hold: assert property (@(posedge clk) disable iff (rst)
		host_awvalid && !host_awready |=> host_awvalid && $stable(host_awaddr));

	a_w_hold: assert property (@(posedge clk) disable iff (rst)
		host_wvalid && !host_wready |=> host_wvalid && $stable({host_wdata, host_wlast}));

endmodule

/* verilog/completion_tracker.sv */
// Channel queue, write-response credits, per-channel counters and reads
`timescale 1ns/1ns
`include "pcim_dma_defines.svh"

module completion_tracker (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      aw_issued,
	input  logic [`DMA_CHAN_W-1:0]    aw_chan,
	output logic                      chan_full,
	input  logic                      host_bvalid,
	input  logic                      sr_valid,
	input  logic                      sr_write,
	input  logic [`DMA_SR_ADDR_W-1:0] sr_addr,
	output logic                      resp_valid,
	output logic [`DMA_STAT_W-1:0]    resp_data
);
	localparam int NUM_CHAN = 1 << `DMA_CHAN_W;
	localparam int CRED_W   = `DMA_FIFO_LD + 2;

	logic [`DMA_CHAN_W-1:0] head_chan;
	logic                   cq_empty;
	logic                   done;
	logic [CRED_W-1:0]      bcreds;
	logic [`DMA_STAT_W-1:0] counts [NUM_CHAN];

	// One entry per write in flight, in issue order
	dma_fifo #(
		.WIDTH(`DMA_CHAN_W),
		.LOG_DEPTH(`DMA_FIFO_LD)
	) chan_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(aw_issued),
		.wr_data(aw_chan),
		.full(chan_full),
		.rd_en(done),
		.rd_data(head_chan),
		.empty(cq_empty)
	);

	// Responses come back in order, so the head owns the oldest one
	assign done = !cq_empty && (bcreds != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			bcreds <= '0;
			for (int i = 0; i < NUM_CHAN; i++)
				counts[i] <= '0;
		end else begin
			bcreds <= bcreds + CRED_W'(host_bvalid) - CRED_W'(done);
			for (int i = 0; i < NUM_CHAN; i++) begin
				if (done && head_chan == `DMA_CHAN_W'(i))
					counts[i] <= counts[i] + 1'b1;
			end
		end
	end

	// Counter select is a qword index
	always_ff @(posedge clk) begin
		if (rst)
			resp_valid <= 1'b0;
		else
			resp_valid <= sr_valid && !sr_write;
		resp_data <= counts[sr_addr[3 +: `DMA_CHAN_W]];
	end

	// A held response always has a write waiting for it
	a_resp_has_write: assert property (@(posedge clk) disable iff (rst)
		bcreds != '0 |-> !cq_empty);

endmodule

/* verilog/pcim_dma.sv */
// Card-to-host DMA top level, three pipeline stages on plain ports
`timescale 1ns/1ns
`include "pcim_dma_defines.svh"

module pcim_dma (
	input  logic                      clk,
	input  logic                      rst,

	// Register port
	input  logic                      sr_valid,
	input  logic                      sr_write,
	input  logic [`DMA_SR_ADDR_W-1:0] sr_addr,
	input  logic [63:0]               sr_data,
	output logic                      resp_valid,
	output logic [`DMA_STAT_W-1:0]    resp_data,

	// Card memory reads
	output logic [`DMA_ADDR_W-1:0]    mem_araddr,
	output logic                      mem_arvalid,
	input  logic                      mem_arready,
	input  logic [`DMA_DATA_W-1:0]    mem_rdata,
	input  logic                      mem_rlast,
	input  logic                      mem_rvalid,
	output logic                      mem_rready,

	// Host memory writes
	output logic [`DMA_ADDR_W-1:0]    host_awaddr,
	output logic                      host_awvalid,
	input  logic                      host_awready,
	output logic [`DMA_DATA_W-1:0]    host_wdata,
	output logic                      host_wlast,
	output logic                      host_wvalid,
	input  logic                      host_wready,
	input  logic                      host_bvalid
);
	burst_if bif ();

	logic                   chan_full;
	logic                   aw_issued;
	logic [`DMA_CHAN_W-1:0] aw_chan;

	burst_issuer issuer (
		.clk(clk), .rst(rst),
		.sr_valid(sr_valid), .sr_write(sr_write), .sr_data(sr_data),
		.mem_araddr(mem_araddr), .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
		.burst(bif.issuer)
	);

	write_scheduler scheduler (
		.clk(clk), .rst(rst),
		.burst(bif.scheduler),
		.mem_rdata(mem_rdata), .mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
		.host_awaddr(host_awaddr), .host_awvalid(host_awvalid), .host_awready(host_awready),
		.host_wdata(host_wdata), .host_wlast(host_wlast),
		.host_wvalid(host_wvalid), .host_wready(host_wready),
		.chan_full(chan_full), .aw_issued(aw_issued), .aw_chan(aw_chan)
	);

	completion_tracker tracker (
		.clk(clk), .rst(rst),
		.aw_issued(aw_issued), .aw_chan(aw_chan), .chan_full(chan_full),
		.host_bvalid(host_bvalid),
		.sr_valid(sr_valid), .sr_write(sr_write), .sr_addr(sr_addr),
		.resp_valid(resp_valid), .resp_data(resp_data)
	);

endmodule

/* tb/pcim_dma_tb.sv */
// Testbench for the card-to-host DMA engine
// Command table, card and host memory models with random stalls, checks
`timescale 1ns/1ns
`include "pcim_dma_defines.svh"

module pcim_dma_tb;
	localparam int NCMD        = 6;
	localparam int NUM_CHAN    = 1 << `DMA_CHAN_W;
	localparam int BEATS       = `DMA_BURST_BEATS;
	localparam int BURST_BYTES = `DMA_BURST_BEATS * `DMA_DATA_W / 8;
	localparam int TIMEOUT     = 20000;
	localparam int DRAIN_READS = 50;
	localparam logic [31:0] PATTERN = 32'h5a5a0000;

	logic                      clk;
	logic                      rst;
	logic                      sr_valid;
	logic                      sr_write;
	logic [`DMA_SR_ADDR_W-1:0] sr_addr;
	logic [63:0]               sr_data;
	logic                      resp_valid;
	logic [`DMA_STAT_W-1:0]    resp_data;
	logic [`DMA_ADDR_W-1:0]    mem_araddr;
	logic                      mem_arvalid;
	logic                      mem_arready;
	logic [`DMA_DATA_W-1:0]    mem_rdata;
	logic                      mem_rlast;
	logic                      mem_rvalid;
	logic                      mem_rready;
	logic [`DMA_ADDR_W-1:0]    host_awaddr;
	logic                      host_awvalid;
	logic                      host_awready;
	logic [`DMA_DATA_W-1:0]    host_wdata;
	logic                      host_wlast;
	logic                      host_wvalid;
	logic                      host_wready;
	logic                      host_bvalid;

	// Command table: channel, bursts minus one, card index, host index
	logic [`DMA_CHAN_W-1:0]     tbl_chan  [NCMD] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd1, 2'd0};
	logic [`DMA_CNT_W-1:0]      tbl_count [NCMD] = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd2, 8'd3};
	logic [`DMA_CARD_IDX_W-1:0] tbl_card  [NCMD] = '{16'h0010, 16'h0100, 16'h1234,
		16'hfff0, 16'h0400, 16'h2000};
	logic [`DMA_HOST_IDX_W-1:0] tbl_host  [NCMD] = '{20'h00100, 20'h02000, 20'h40000,
		20'hab000, 20'h00800, 20'h12340};

	logic [31:0] exp_card [$];
	logic [31:0] exp_host [$];
	int          exp_cnt  [NUM_CHAN];
	logic [31:0] card_q   [$];
	logic [31:0] lcg_state = 32'hb799;
	bit          run_models = 1'b0;
	bit          r_hold = 1'b0;
	int          rd_beat = 0;
	int          ar_idx = 0;
	int          aw_idx = 0;
	int          w_beats = 0;
	int          wlast_cnt = 0;
	int          b_sent = 0;

	pcim_dma u_pcim_dma (
		.clk(clk), .rst(rst),
		.sr_valid(sr_valid), .sr_write(sr_write), .sr_addr(sr_addr), .sr_data(sr_data),
		.resp_valid(resp_valid), .resp_data(resp_data),
		.mem_araddr(mem_araddr), .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
		.mem_rdata(mem_rdata), .mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
		.host_awaddr(host_awaddr), .host_awvalid(host_awvalid), .host_awready(host_awready),
		.host_wdata(host_wdata), .host_wlast(host_wlast),
		.host_wvalid(host_wvalid), .host_wready(host_wready),
		.host_bvalid(host_bvalid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// LCG step, ready about three times in four
	function automatic bit next_rand_ready();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[18:17] != 2'b00;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic read_counter(input int chan, output logic [`DMA_STAT_W-1:0] value);
		check("resp_valid", 32'(resp_valid), 32'd0);
		sr_valid = 1'b1;
		sr_write = 1'b0;
		sr_addr  = 8'(chan << 3);
		@(negedge clk);
		sr_valid = 1'b0;
		check("resp_valid", 32'(resp_valid), 32'd1);
		value = resp_data;
		@(negedge clk);
		check("resp_valid", 32'(resp_valid), 32'd0);
	endtask

	task automatic write_command(input int i);
		sr_valid = 1'b1;
		sr_write = 1'b1;
		sr_data  = 64'({tbl_chan[i], tbl_count[i], tbl_card[i], tbl_host[i]});
		@(negedge clk);
		sr_valid = 1'b0;
		sr_write = 1'b0;
	endtask

	// Card and host side inputs change on falling edges only
	initial begin
		mem_arready  = 1'b0;
		mem_rvalid   = 1'b0;
		mem_rdata    = '0;
		mem_rlast    = 1'b0;
		host_awready = 1'b0;
		host_wready  = 1'b0;
		host_bvalid  = 1'b0;
		forever begin
			@(negedge clk);
			if (run_models) begin
				mem_arready  = next_rand_ready();
				host_awready = next_rand_ready();
				host_wready  = next_rand_ready();
				// Response only once both address and last beat have been taken
				host_bvalid  = next_rand_ready() && (b_sent < aw_idx) && (b_sent < wlast_cnt);
				mem_rvalid   = (card_q.size() != 0) && (r_hold || next_rand_ready());
				if (card_q.size() != 0) begin
					mem_rdata = (card_q[0] ^ PATTERN) + 32'(rd_beat);
					mem_rlast = rd_beat == BEATS - 1;
				end
			end
		end
	end

	// Handshakes seen at the rising edge
	always @(posedge clk) begin
		if (!rst) begin
			if (mem_arvalid && mem_arready) begin
				if (ar_idx >= exp_card.size())
					abort_run("Card read issued beyond the expected bursts");
				check("mem_araddr", mem_araddr, exp_card[ar_idx]);
				card_q.push_back(mem_araddr);
				ar_idx++;
			end
			r_hold = mem_rvalid && !mem_rready;
			if (mem_rvalid && mem_rready) begin
				if (rd_beat == BEATS - 1) begin
					void'(card_q.pop_front());
					rd_beat = 0;
				end else begin
					rd_beat++;
				end
			end
			if (host_awvalid && host_awready) begin
				if (aw_idx >= exp_host.size())
					abort_run("Host write address issued beyond the expected bursts");
				check("host_awaddr", host_awaddr, exp_host[aw_idx]);
				aw_idx++;
			end
			if (host_wvalid && host_wready) begin
				if (w_beats >= exp_card.size() * BEATS)
					abort_run("Host write beat beyond the expected data");
				check("host_wdata", host_wdata,
					(exp_card[w_beats / BEATS] ^ PATTERN) + 32'(w_beats % BEATS));
				check("host_wlast", 32'(host_wlast), 32'(w_beats % BEATS == BEATS - 1));
				if (host_wlast)
					wlast_cnt++;
				w_beats++;
			end
			if (host_bvalid)
				b_sent++;
		end
	end

	initial begin
		logic [`DMA_STAT_W-1:0] value;
		int total;
		int t;
		rst      = 1'b1;
		sr_valid = 1'b0;
		sr_write = 1'b0;
		sr_addr  = '0;
		sr_data  = '0;

		// Expected bursts in table order
		for (int c = 0; c < NUM_CHAN; c++)
			exp_cnt[c] = 0;
		for (int i = 0; i < NCMD; i++) begin
			for (int k = 0; k <= int'(tbl_count[i]); k++) begin
				exp_card.push_back((32'(tbl_card[i]) + 32'(k)) * 32'(BURST_BYTES));
				exp_host.push_back((32'(tbl_host[i]) + 32'(k)) * 32'(BURST_BYTES));
			end
			exp_cnt[tbl_chan[i]] += int'(tbl_count[i]) + 1;
		end
		total = exp_card.size();

		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check("mem_arvalid", 32'(mem_arvalid), 32'd0);
		check("host_awvalid", 32'(host_awvalid), 32'd0);
		check("host_wvalid", 32'(host_wvalid), 32'd0);
		check("resp_valid", 32'(resp_valid), 32'd0);
		// Empty data buffer takes card beats
		check("mem_rready", 32'(mem_rready), 32'd1);
		for (int c = 0; c < NUM_CHAN; c++) begin
			read_counter(c, value);
			check($sformatf("counter[%0d]", c), value, 32'd0);
		end

		// Models start on the next falling edge
		@(posedge clk);
		run_models = 1'b1;
		@(negedge clk);
		for (int i = 0; i < NCMD; i++)
			write_command(i);

		t = 0;
		while (b_sent < total && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (b_sent < total)
			abort_run("Timed out waiting for the host write responses");

		// Counters may trail the last response by a cycle
		for (int c = 0; c < NUM_CHAN; c++) begin
			t = 0;
			read_counter(c, value);
			while (value != 32'(exp_cnt[c]) && t < DRAIN_READS) begin
				read_counter(c, value);
				t++;
			end
			check($sformatf("counter[%0d]", c), value, 32'(exp_cnt[c]));
		end

		// Nothing left in flight once every burst has completed
		check("mem_arvalid", 32'(mem_arvalid), 32'd0);
		check("host_awvalid", 32'(host_awvalid), 32'd0);
		check("host_wvalid", 32'(host_wvalid), 32'd0);
		check("mem_rready", 32'(mem_rready), 32'd1);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* pcim_dma.f */
+incdir+include
verilog/pcim_dma_pkg.sv
verilog/dma_fifo.sv
verilog/burst_issuer.sv
verilog/write_scheduler.sv
verilog/completion_tracker.sv
verilog/pcim_dma.sv
tb/pcim_dma_tb.sv

/* Makefile */
# Verilator lint, simulation and clean for the card-to-host DMA engine
VERILATOR  ?= verilator
FILELIST   ?= pcim_dma.f
TOP_RTL    ?= pcim_dma
TOP_TB     ?= pcim_dma_tb
OBJ_DIR    ?= obj_dir
INC_DIR    ?= include
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing
RTL_FILES  ?= verilog/pcim_dma_pkg.sv verilog/dma_fifo.sv verilog/burst_issuer.sv \
              verilog/write_scheduler.sv verilog/completion_tracker.sv verilog/pcim_dma.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+$(INC_DIR) $(RTL_FILES) --top-module $(TOP_RTL)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP_TB) --Mdir $(OBJ_DIR) -o V$(TOP_TB)
	./$(OBJ_DIR)/V$(TOP_TB)

clean:
	rm -rf $(OBJ_DIR)
